/* hdl/mmuPkg.sv */
package mmuPkg;

    // Sv32 page numbers and addresses
    typedef logic [19:0] vpnT;       // Upper half indexes level 1, lower half level 0
    typedef logic [21:0] ppnT;       // Bits 21..20 set means the page is outside memory
    typedef logic [31:0] physAddrT;
    typedef logic [31:0] pteT;

    typedef logic [2:0] rwxT;        // Read in the top bit, execute in the bottom bit

    typedef logic reqIdT;            // Tags a walk with the buffer that asked for it

    typedef enum logic [2:0] {
        walkIdle,
        walkL1Req,
        walkL1Wait,
        walkL0Req,
        walkL0Wait,
        walkDone
    } walkStateT;

    localparam reqIdT reqFetch = 1'b0;
    localparam reqIdT reqData = 1'b1;

    // The set count of a buffer follows from these two
    localparam int tlbSize = 8;
    localparam int tlbAssoc = 4;

    // Bit positions inside a page-table entry
    localparam int pteV = 0;
    localparam int pteR = 1;
    localparam int pteW = 2;
    localparam int pteX = 3;
    localparam int pteU = 4;
    localparam int pteG = 5;
    localparam int ptePpnLsb = 10;

endpackage

/* hdl/walkResultIf.sv */
`timescale 1ns/100ps

interface walkResultIf;
    import mmuPkg::*;

    logic valid;                 // One cycle per finished walk
    logic busy;
    reqIdT rqId;
    vpnT vpn;
    ppnT ppn;
    rwxT rwx;
    logic user;
    logic globl;
    logic isSuper;
    logic pageFault;

    modport walker (
        output valid, busy, rqId, vpn, ppn, rwx, user, globl, isSuper, pageFault
    );

    modport buffer (
        input valid, busy, rqId, vpn, ppn, rwx, user, globl, isSuper, pageFault
    );

endinterface

/* hdl/translationBuffer.sv */
`timescale 1ns/100ps

module translationBuffer #(
    parameter bit isFetch = 1'b1
) (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic lookupValid,
    input  mmuPkg::vpnT lookupVpn,
    output logic hit,
    output mmuPkg::ppnT ppn,
    output mmuPkg::rwxT rwx,
    output logic user,
    output logic isSuper,
    output logic pageFault,
    output logic accessFault,
    output logic missValid,
    output mmuPkg::vpnT missVpn,
    input  logic missReady,
    walkResultIf.buffer walk
);
    import mmuPkg::*;

    localparam int setCount = tlbSize / tlbAssoc;
    localparam int setBits = $clog2(setCount);
    localparam int wayBits = $clog2(tlbAssoc);
    localparam int tagBits = 20 - setBits;
    localparam reqIdT ownId = isFetch ? reqFetch : reqData;

    logic entryValid [setCount][tlbAssoc];
    logic [tagBits-1:0] entryTag [setCount][tlbAssoc];
    logic [19:0] entryPpn [setCount][tlbAssoc];
    rwxT entryRwx [setCount][tlbAssoc];
    logic entryUser [setCount][tlbAssoc];
    logic entrySuper [setCount][tlbAssoc];
    logic entryPageFault [setCount][tlbAssoc];
    logic entryAccessFault [setCount][tlbAssoc];
    logic [wayBits-1:0] rrCounter [setCount];

    logic [setBits-1:0] lookupSet;
    logic [tagBits-1:0] lookupTag;
    logic [tlbAssoc-1:0] wayMatch;
    logic [wayBits-1:0] hitWay;
    logic [setBits-1:0] fillSet;
    logic [wayBits-1:0] fillWay;
    logic acceptFill;
    logic ignoreWalk;            // Set by clear until the walk in flight has ended
    logic walkPending;

    assign lookupSet = lookupVpn[setBits-1:0];
    assign lookupTag = lookupVpn[19:setBits];
    assign fillSet = walk.vpn[setBits-1:0];
    assign fillWay = rrCounter[fillSet];
    assign acceptFill = walk.valid && !ignoreWalk && walk.rqId == ownId;

    always_comb begin
        for (int w = 0; w < tlbAssoc; w++) begin
            if (entrySuper[lookupSet][w]) begin
                wayMatch[w] = entryValid[lookupSet][w] &&
                    entryTag[lookupSet][w][tagBits-1:10-setBits] == lookupVpn[19:10];
            end else begin
                wayMatch[w] = entryValid[lookupSet][w] && entryTag[lookupSet][w] == lookupTag;
            end
        end
    end

    always_comb begin
        hit = 1'b0;
        hitWay = '0;
        ppn = '0;
        rwx = '0;
        user = 1'b0;
        isSuper = 1'b0;
        pageFault = 1'b0;
        accessFault = 1'b0;
        for (int w = 0; w < tlbAssoc; w++) begin
            if (lookupValid && wayMatch[w]) begin
                hit = 1'b1;
                hitWay = wayBits'(w);
                rwx = entryRwx[lookupSet][w];
                user = entryUser[lookupSet][w];
                isSuper = entrySuper[lookupSet][w];
                pageFault = entryPageFault[lookupSet][w];
                accessFault = entryAccessFault[lookupSet][w];
                if (entrySuper[lookupSet][w]) begin
                    ppn = {2'b00, entryPpn[lookupSet][w][19:10], lookupVpn[9:0]};
                end else begin
                    ppn = {2'b00, entryPpn[lookupSet][w]};
                end
            end
        end
    end

    assign missValid = lookupValid && !hit && !walkPending;
    assign missVpn = lookupVpn;

    always_ff @(posedge clk) begin
        if (rst) begin
            ignoreWalk <= 1'b0;
            walkPending <= 1'b0;
            for (int s = 0; s < setCount; s++) begin
                rrCounter[s] <= '0;
            end
        end else begin
            if (clear) begin
                ignoreWalk <= 1'b1;
            end else if (!walk.busy) begin
                ignoreWalk <= 1'b0;
            end
            if (missValid && missReady) begin
                walkPending <= 1'b1;
            end else if (walk.valid && walk.rqId == ownId) begin
                walkPending <= 1'b0;
            end
            if (!clear && hit && hitWay == rrCounter[lookupSet]) begin
                rrCounter[lookupSet] <= rrCounter[lookupSet] + 1'b1;  // Hit on the victim
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            for (int s = 0; s < setCount; s++) begin
                for (int w = 0; w < tlbAssoc; w++) begin
                    entryValid[s][w] <= 1'b0;
                end
            end
        end else if (acceptFill) begin
            entryValid[fillSet][fillWay] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (acceptFill) begin
            entryTag[fillSet][fillWay] <= walk.vpn[19:setBits];
            entryPpn[fillSet][fillWay] <= walk.ppn[19:0];
            entryRwx[fillSet][fillWay] <= walk.rwx;
            entryUser[fillSet][fillWay] <= walk.user;
            entrySuper[fillSet][fillWay] <= walk.isSuper;
            entryPageFault[fillSet][fillWay] <= walk.pageFault;
            entryAccessFault[fillSet][fillWay] <= walk.ppn[21:20] != 2'b00;
        end
    end

endmodule

/* hdl/pageWalker.sv */
`timescale 1ns/100ps

module pageWalker (
    input  logic clk,
    input  logic rst,
    input  mmuPkg::ppnT rootPpn,
    input  logic fetchMissValid,
    input  logic dataMissValid,
    input  mmuPkg::vpnT fetchMissVpn,
    input  mmuPkg::vpnT dataMissVpn,
    output logic fetchMissReady,
    output logic dataMissReady,
    output logic memReqValid,
    output mmuPkg::physAddrT memReqAddr,
    input  logic memReqReady,
    input  logic memRspValid,
    input  mmuPkg::pteT memRspData,
    walkResultIf.walker result
);
    import mmuPkg::*;

    walkStateT state;
    reqIdT curId;
    vpnT curVpn;
    vpnT pickVpn;
    physAddrT reqAddr;

    ppnT resPpn;
    rwxT resRwx;
    logic resUser;
    logic resGlobl;
    logic resSuper;
    logic resFault;

    logic fetchTake;
    logic dataTake;
    ppnT rspPpn;
    rwxT rspRwx;
    logic rspBadPte;

    // Requests are only taken while idle, and fetch goes first
    assign fetchMissReady = state == walkIdle;
    assign dataMissReady = state == walkIdle && !fetchMissValid;
    assign fetchTake = fetchMissValid && fetchMissReady;
    assign dataTake = dataMissValid && dataMissReady;
    assign pickVpn = fetchTake ? fetchMissVpn : dataMissVpn;

    assign memReqValid = state == walkL1Req || state == walkL0Req;
    assign memReqAddr = reqAddr;

    assign rspPpn = memRspData[31:ptePpnLsb];
    assign rspRwx = {memRspData[pteR], memRspData[pteW], memRspData[pteX]};
    assign rspBadPte = !memRspData[pteV] || (memRspData[pteW] && !memRspData[pteR]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= walkIdle;
        end else begin
            case (state)
                walkIdle: begin
                    if (fetchTake || dataTake) begin
                        curId <= fetchTake ? reqFetch : reqData;
                        curVpn <= pickVpn;
                        reqAddr <= {rootPpn[19:0], pickVpn[19:10], 2'b00};  // Root table entry
                        state <= walkL1Req;
                    end
                end
                walkL1Req: begin
                    if (memReqReady) begin
                        state <= walkL1Wait;
                    end
                end
                walkL1Wait: begin
                    if (memRspValid) begin
                        resPpn <= rspPpn;
                        resRwx <= rspRwx;
                        resUser <= memRspData[pteU];
                        resGlobl <= memRspData[pteG];
                        if (rspBadPte) begin
                            resSuper <= 1'b0;
                            resFault <= 1'b1;
                            state <= walkDone;
                        end else if (rspRwx != 3'b000) begin
                            resSuper <= 1'b1;
                            resFault <= rspPpn[9:0] != 10'd0;  // Misaligned superpage
                            state <= walkDone;
                        end else begin
                            reqAddr <= {rspPpn[19:0], curVpn[9:0], 2'b00};
                            state <= walkL0Req;
                        end
                    end
                end
                walkL0Req: begin
                    if (memReqReady) begin
                        state <= walkL0Wait;
                    end
                end
                walkL0Wait: begin
                    if (memRspValid) begin
                        resPpn <= rspPpn;
                        resRwx <= rspRwx;
                        resUser <= memRspData[pteU];
                        resGlobl <= memRspData[pteG];
                        resSuper <= 1'b0;
                        resFault <= rspBadPte || rspRwx == 3'b000;  // Level 0 must be a leaf
                        state <= walkDone;
                    end
                end
                walkDone: begin
                    state <= walkIdle;
                end
                default: begin
                    state <= walkIdle;
                end
            endcase
        end
    end

    assign result.valid = state == walkDone;
    assign result.busy = state != walkIdle;
    assign result.rqId = curId;
    assign result.vpn = curVpn;
    assign result.ppn = resPpn;
    assign result.rwx = resRwx;
    assign result.user = resUser;
    assign result.globl = resGlobl;
    assign result.isSuper = resSuper;
    assign result.pageFault = resFault;

endmodule

/* hdl/mmuTop.sv */
`timescale 1ns/100ps

module mmuTop (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  mmuPkg::ppnT rootPpn,

    input  logic fetchValid,
    input  mmuPkg::vpnT fetchVpn,
    output logic fetchHit,
    output mmuPkg::ppnT fetchPpn,
    output mmuPkg::rwxT fetchRwx,
    output logic fetchUser,
    output logic fetchSuper,
    output logic fetchPageFault,
    output logic fetchAccessFault,

    input  logic dataValid,
    input  mmuPkg::vpnT dataVpn,
    output logic dataHit,
    output mmuPkg::ppnT dataPpn,
    output mmuPkg::rwxT dataRwx,
    output logic dataUser,
    output logic dataSuper,
    output logic dataPageFault,
    output logic dataAccessFault,

    output logic memReqValid,
    output mmuPkg::physAddrT memReqAddr,
    input  logic memReqReady,
    input  logic memRspValid,
    input  mmuPkg::pteT memRspData
);
    import mmuPkg::*;

    logic fetchMissValid;
    logic fetchMissReady;
    vpnT fetchMissVpn;
    logic dataMissValid;
    logic dataMissReady;
    vpnT dataMissVpn;

    walkResultIf walkBus_i ();

    translationBuffer #(.isFetch(1'b1)) fetchTlb_i (
        .clk, .rst, .clear,
        .lookupValid(fetchValid), .lookupVpn(fetchVpn),
        .hit(fetchHit), .ppn(fetchPpn), .rwx(fetchRwx), .user(fetchUser),
        .isSuper(fetchSuper), .pageFault(fetchPageFault), .accessFault(fetchAccessFault),
        .missValid(fetchMissValid), .missVpn(fetchMissVpn), .missReady(fetchMissReady),
        .walk(walkBus_i.buffer)
    );

    translationBuffer #(.isFetch(1'b0)) dataTlb_i (
        .clk, .rst, .clear,
        .lookupValid(dataValid), .lookupVpn(dataVpn),
        .hit(dataHit), .ppn(dataPpn), .rwx(dataRwx), .user(dataUser),
        .isSuper(dataSuper), .pageFault(dataPageFault), .accessFault(dataAccessFault),
        .missValid(dataMissValid), .missVpn(dataMissVpn), .missReady(dataMissReady),
        .walk(walkBus_i.buffer)
    );

    pageWalker walker_i (
        .clk, .rst, .rootPpn,
        .fetchMissValid, .dataMissValid, .fetchMissVpn, .dataMissVpn,
        .fetchMissReady, .dataMissReady,
        .memReqValid, .memReqAddr, .memReqReady, .memRspValid, .memRspData,
        .result(walkBus_i.walker)
    );

endmodule

/* bench/pageTableModel.sv */
`timescale 1ns/100ps

module pageTableModel (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    input  mmuPkg::physAddrT reqAddr,
    output logic reqReady,
    output logic rspValid,
    output mmuPkg::pteT rspData
);
    import mmuPkg::*;

    // Root table at ppn 0x00100, one level-0 table at ppn 0x00101
    function automatic pteT pteAt(input physAddrT addr);
        pteT pte;
        logic [9:0] idx;
        idx = addr[11:2];
        pte = '0;
        if (addr[31:12] == 20'h00100) begin
            if (idx == 10'd1) begin
                pte = {22'h00101, 10'h001};                  // Pointer to the level-0 table
            end else if (idx == 10'd2) begin
                pte = {22'h00C00, 10'h01F};                  // Superpage with rwx and user
            end
        end else if (addr[31:12] == 20'h00101) begin
            if (idx < 10'd10) begin
                pte[31:10] = 22'h08000 + 22'(idx) * 22'd5;
                pte[4:0] = idx[0] ? 5'b01011 : {idx[2], 4'b0111};
            end else if (idx == 10'd11) begin
                pte = {22'h100050, 10'h007};                 // Outside the 32-bit space
            end
        end
        return pte;                                          // Index 10 stays invalid
    endfunction

    initial begin
        int waitCycles;
        int latency;
        physAddrT addr;
        void'($urandom(97572));
        reqReady = 1'b0;
        rspValid = 1'b0;
        rspData = '0;
        forever begin
            @(posedge clk);
            #1;
            rspValid = 1'b0;
            if (reqValid && !rst) begin
                waitCycles = $urandom_range(2, 0);
                repeat (waitCycles) begin
                    @(posedge clk);
                    #1;
                end
                addr = reqAddr;
                reqReady = 1'b1;
                @(posedge clk);                              // Request taken at this edge
                #1;
                reqReady = 1'b0;
                latency = $urandom_range(3, 1);
                repeat (latency - 1) begin
                    @(posedge clk);
                    #1;
                end
                rspData = pteAt(addr);
                rspValid = 1'b1;
            end
        end
    end

endmodule

/* bench/mmuTb.sv */
`timescale 1ns/100ps

module mmuTb;
    import mmuPkg::*;

    localparam ppnT tableRoot = 22'h00100;
    localparam int cycleLimit = 3000;    // Up to 4 walks of 14 cycles for each of 30 lookups plus margin

    logic clk = 1'b0;
    logic rst;
    logic clear;
    ppnT rootPpn;
    logic fetchValid, dataValid;
    vpnT fetchVpn, dataVpn;
    logic fetchHit, dataHit;
    ppnT fetchPpn, dataPpn;
    rwxT fetchRwx, dataRwx;
    logic fetchUser, dataUser, fetchSuper, dataSuper;
    logic fetchPageFault, dataPageFault, fetchAccessFault, dataAccessFault;
    logic memReqValid, memReqReady, memRspValid;
    physAddrT memReqAddr;
    pteT memRspData;

    ppnT fetchExpPpn, dataExpPpn;
    rwxT fetchExpRwx, dataExpRwx;
    logic fetchExpUser, dataExpUser, fetchExpSuper, dataExpSuper;
    logic fetchExpPf, dataExpPf, fetchExpAf, dataExpAf;
    logic fetchFresh, dataFresh;         // First cycle of a lookup the buffer cannot hold yet
    logic rootReadSinceClear;            // A walk begun after the last clear has read the root table
    vpnT fetchSeen[$];
    vpnT dataSeen[$];
    int hitErrors = 0;
    int valueErrors = 0;
    int faultErrors = 0;
    int cycleCount = 0;

    always #20 clk = ~clk;

    mmuTop mmuTop_i (.*);

    pageTableModel tableModel_i (
        .clk, .rst,
        .reqValid(memReqValid), .reqAddr(memReqAddr), .reqReady(memReqReady),
        .rspValid(memRspValid), .rspData(memRspData)
    );

    // Every walk starts with a read of the root table
    always @(posedge clk) begin
        if (rst || clear) begin
            rootReadSinceClear <= 1'b0;
        end else if (memReqValid && memReqReady && memReqAddr[31:12] == tableRoot[19:0]) begin
            rootReadSinceClear <= 1'b1;
        end
    end

    function automatic pteT tablePte(input physAddrT addr);
        pteT pte;
        logic [9:0] idx;
        idx = addr[11:2];
        pte = '0;
        if (addr[31:12] == 20'h00100 && idx == 10'd1) begin
            pte = {22'h00101, 10'h001};
        end
        if (addr[31:12] == 20'h00100 && idx == 10'd2) begin
            pte = {22'h00C00, 10'h01F};
        end
        if (addr[31:12] == 20'h00101 && idx < 10'd10) begin
            pte[31:10] = 22'h08000 + 22'(idx) * 22'd5;
            pte[4:0] = idx[0] ? 5'b01011 : {idx[2], 4'b0111};
        end
        if (addr[31:12] == 20'h00101 && idx == 10'd11) begin
            pte = {22'h100050, 10'h007};
        end
        return pte;
    endfunction

    function automatic void refTranslate(input vpnT vpn, output ppnT p, output rwxT r,
            output logic u, output logic sup, output logic pf, output logic af);
        pteT pte;
        pte = tablePte({tableRoot[19:0], vpn[19:10], 2'b00});
        sup = pte[3:1] != 3'b000;        // A first-level leaf maps 4 MiB
        if (pte[0] && !sup) begin
            pte = tablePte({pte[29:10], vpn[9:0], 2'b00});
        end
        pf = !pte[0] || (pte[2] && !pte[1]) || pte[3:1] == 3'b000 ||
            (sup && pte[19:10] != 10'd0);
        af = pte[31:30] != 2'b00;
        p = sup ? {pte[31:20], vpn[9:0]} : pte[31:10];
        r = {pte[1], pte[2], pte[3]};
        u = pte[4];
    endfunction

    // One key per page, so every vpn of the superpage shares one
    function automatic vpnT pageKey(input vpnT vpn);
        ppnT p;
        rwxT r;
        logic u, sup, pf, af;
        refTranslate(vpn, p, r, u, sup, pf, af);
        return (sup && !pf) ? {vpn[19:10], 10'h000} : vpn;
    endfunction

    function automatic bit wasSeen(input bit onData, input vpnT vpn);
        vpnT key;
        key = pageKey(vpn);
        if (onData) begin
            foreach (dataSeen[i]) begin
                if (dataSeen[i] == key) return 1'b1;
            end
        end else begin
            foreach (fetchSeen[i]) begin
                if (fetchSeen[i] == key) return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    always_comb refTranslate(fetchVpn, fetchExpPpn, fetchExpRwx, fetchExpUser, fetchExpSuper,
        fetchExpPf, fetchExpAf);
    always_comb refTranslate(dataVpn, dataExpPpn, dataExpRwx, dataExpUser, dataExpSuper,
        dataExpPf, dataExpAf);

    assert property (@(posedge clk) disable iff (rst) fetchValid && fetchFresh |-> !fetchHit)
        else begin
            hitErrors++;
            $display("Fetch lookup of %h hit before any walk at %0t", $sampled(fetchVpn), $time);
        end
    assert property (@(posedge clk) disable iff (rst) dataValid && dataFresh |-> !dataHit)
        else begin
            hitErrors++;
            $display("Data lookup of %h hit before any walk at %0t", $sampled(dataVpn), $time);
        end
    assert property (@(posedge clk) disable iff (rst) !rootReadSinceClear |-> !fetchHit && !dataHit)
        else begin
            hitErrors++;
            $display("mismatch at %0t: hit before any walk begun after reset or clear", $time);
        end
    assert property (@(posedge clk) disable iff (rst)
        fetchHit && !fetchExpPf && !fetchExpAf |-> fetchPpn == fetchExpPpn)
        else begin
            valueErrors++;
            $display("mismatch at %0t: fetch vpn %h gave ppn %h, expected %h", $time,
                $sampled(fetchVpn), $sampled(fetchPpn), $sampled(fetchExpPpn));
        end
    assert property (@(posedge clk) disable iff (rst)
        dataHit && !dataExpPf && !dataExpAf |-> dataPpn == dataExpPpn)
        else begin
            valueErrors++;
            $display("mismatch at %0t: data vpn %h gave ppn %h, expected %h", $time,
                $sampled(dataVpn), $sampled(dataPpn), $sampled(dataExpPpn));
        end
    assert property (@(posedge clk) disable iff (rst) fetchHit && !fetchExpPf |->
        {fetchRwx, fetchUser, fetchSuper} == {fetchExpRwx, fetchExpUser, fetchExpSuper})
        else begin
            valueErrors++;
            $display("mismatch at %0t: fetch vpn %h has wrong rwx, user or isSuper", $time,
                $sampled(fetchVpn));
        end
    assert property (@(posedge clk) disable iff (rst) dataHit && !dataExpPf |->
        {dataRwx, dataUser, dataSuper} == {dataExpRwx, dataExpUser, dataExpSuper})
        else begin
            valueErrors++;
            $display("mismatch at %0t: data vpn %h has wrong rwx, user or isSuper", $time,
                $sampled(dataVpn));
        end
    assert property (@(posedge clk) disable iff (rst) fetchHit |->
        fetchPageFault == fetchExpPf && (fetchExpPf || fetchAccessFault == fetchExpAf))
        else begin
            faultErrors++;
            $display("mismatch at %0t: fetch vpn %h has wrong fault flags", $time,
                $sampled(fetchVpn));
        end
    assert property (@(posedge clk) disable iff (rst) dataHit |->
        dataPageFault == dataExpPf && (dataExpPf || dataAccessFault == dataExpAf))
        else begin
            faultErrors++;
            $display("mismatch at %0t: data vpn %h has wrong fault flags", $time,
                $sampled(dataVpn));
        end

    // Holds the lookup until hit, then one more edge so the checks sample it
    task automatic lookup(input bit onData, input vpnT vpn);
        bit fresh;
        fresh = !wasSeen(onData, vpn);
        if (onData) begin
            dataVpn = vpn;
            dataValid = 1'b1;
            dataFresh = fresh;
        end else begin
            fetchVpn = vpn;
            fetchValid = 1'b1;
            fetchFresh = fresh;
        end
        @(posedge clk);
        #1;
        dataFresh = onData ? 1'b0 : dataFresh;
        fetchFresh = onData ? fetchFresh : 1'b0;
        while (!(onData ? dataHit : fetchHit)) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        if (onData) begin
            dataValid = 1'b0;
            dataSeen.push_back(pageKey(vpn));
        end else begin
            fetchValid = 1'b0;
            fetchSeen.push_back(pageKey(vpn));
        end
    endtask

    task automatic pulseClear();
        clear = 1'b1;
        fetchSeen.delete();
        dataSeen.delete();
        @(posedge clk);
        #1;
        clear = 1'b0;
    endtask

    task automatic reportCounts();
        $display("Errors: %0d hit timing, %0d translation, %0d fault",
            hitErrors, valueErrors, faultErrors);
    endtask

    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles while waiting for a hit", cycleLimit);
        reportCounts();
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst = 1'b1;
        clear = 1'b0;
        rootPpn = tableRoot;
        fetchValid = 1'b0;
        fetchVpn = '0;
        fetchFresh = 1'b0;
        dataValid = 1'b0;
        dataVpn = '0;
        dataFresh = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        lookup(1'b0, 20'h00400);
        lookup(1'b1, 20'h00401);
        fork
            lookup(1'b0, 20'h00402);
            lookup(1'b1, 20'h00403);
        join
        lookup(1'b0, 20'h00400);
        lookup(1'b1, 20'h00BFF);                             // Superpage
        lookup(1'b0, 20'h00805);
        lookup(1'b0, 20'h00977);
        lookup(1'b1, 20'h0040A);                             // Invalid entry
        lookup(1'b0, 20'h0040B);
        lookup(1'b1, 20'h00C00);
        for (int i = 0; i < 10; i += 2) lookup(1'b1, 20'h00400 + vpnT'(i));
        for (int i = 4; i < 10; i += 2) lookup(1'b0, 20'h00400 + vpnT'(i));
        for (int i = 0; i < 10; i += 2) lookup(1'b1, 20'h00400 + vpnT'(i));
        fork
            lookup(1'b0, 20'h00407);
            begin
                repeat (3) @(posedge clk);                   // Lands while the walk runs
                #1;
                pulseClear();
            end
        join
        lookup(1'b0, 20'h00400);
        lookup(1'b1, 20'h00805);
        @(posedge clk);
        #1;
        reportCounts();
        if (hitErrors + valueErrors + faultErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/mmuPkg.sv
hdl/walkResultIf.sv
hdl/translationBuffer.sv
hdl/pageWalker.sv
hdl/mmuTop.sv
bench/pageTableModel.sv
bench/mmuTb.sv
